// ==== hdl/helios_cfg_pkg.sv ====
`default_nettype none

package helios_cfg_pkg;

    // data and address width
    localparam int XLEN = 32;

    localparam int ROB_DEPTH_DEFAULT = 8;

    // architectural register index
    localparam int REG_SEL = 5;

    // word alignment of data addresses
    localparam int WORD_BYTES = XLEN / 8;
    localparam int ADDR_LSB = $clog2(WORD_BYTES);

endpackage

`default_nettype wire

// ==== hdl/helios_op_pkg.sv ====
`default_nettype none

package helios_op_pkg;

    import helios_cfg_pkg::*;

    typedef enum logic {
        FU_ALU = 1'b0,
        FU_MEM = 1'b1
    } fu_sel_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_e;

    typedef enum logic {
        MEM_LW = 1'b0,
        MEM_SW = 1'b1
    } mem_op_e;

    // 3 + 32 + 32 bits
    typedef struct packed {
        alu_op_e         op;
        logic [XLEN-1:0] src1;
        logic [XLEN-1:0] src2;
    } alu_req_t;

    // 1 + 32 + 32 + 32 bits
    typedef struct packed {
        mem_op_e         op;
        logic [XLEN-1:0] base;
        logic [XLEN-1:0] wdata;
        logic [XLEN-1:0] imm;
    } mem_req_t;

endpackage

`default_nettype wire

// ==== hdl/issue_slot.sv ====
`default_nettype none

module issue_slot #(
    parameter type payload_t = logic,
    parameter int  TAG_W     = 3
) (
    input  wire logic             clk_i,
    input  wire logic             rst_n_i,
    input  wire logic             load_i,
    input  wire logic [TAG_W-1:0] tag_i,
    input  wire payload_t         payload_i,
    input  wire logic             release_i,
    output logic                  busy_o,
    output logic      [TAG_W-1:0] tag_o,
    output payload_t              payload_o
);

    logic             busy_q;
    logic [TAG_W-1:0] tag_q;
    payload_t         payload_q;

    // a new load wins over a release in the same cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
        end else if (load_i) begin
            busy_q <= 1'b1;
        end else if (release_i) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            tag_q     <= tag_i;
            payload_q <= payload_i;
        end
    end

    assign busy_o    = busy_q;
    assign tag_o     = tag_q;
    assign payload_o = payload_q;

endmodule

`default_nettype wire

// ==== hdl/alu_unit.sv ====
`default_nettype none

module alu_unit
    import helios_cfg_pkg::*;
    import helios_op_pkg::*;
#(
    parameter int ROB_DEPTH = ROB_DEPTH_DEFAULT
) (
    input  wire logic                         clk_i,
    input  wire logic                         rst_n_i,
    input  wire logic                         issue_i,
    input  wire logic [$clog2(ROB_DEPTH)-1:0] tag_i,
    input  wire alu_req_t                     req_i,
    output logic                              busy_o,
    output logic                              wb_valid_o,
    output logic      [$clog2(ROB_DEPTH)-1:0] wb_tag_o,
    output logic      [XLEN-1:0]              wb_data_o
);

    localparam int TAG_W = $clog2(ROB_DEPTH);

    logic             slot_busy;
    logic [TAG_W-1:0] slot_tag;
    alu_req_t         slot_req;
    logic [XLEN-1:0]  result;
    logic             wb_valid_q;
    logic [TAG_W-1:0] wb_tag_q;
    logic [XLEN-1:0]  wb_data_q;

    // held for exactly one cycle, released as the result is registered
    issue_slot #(
        .payload_t(alu_req_t),
        .TAG_W    (TAG_W)
    ) u_slot (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .load_i   (issue_i),
        .tag_i    (tag_i),
        .payload_i(req_i),
        .release_i(slot_busy),
        .busy_o   (slot_busy),
        .tag_o    (slot_tag),
        .payload_o(slot_req)
    );

    always_comb begin
        case (slot_req.op)
            ALU_ADD: result = slot_req.src1 + slot_req.src2;
            ALU_SUB: result = slot_req.src1 - slot_req.src2;
            ALU_AND: result = slot_req.src1 & slot_req.src2;
            ALU_OR:  result = slot_req.src1 | slot_req.src2;
            ALU_XOR: result = slot_req.src1 ^ slot_req.src2;
            ALU_SLL: result = slot_req.src1 << slot_req.src2[4:0];
            ALU_SRL: result = slot_req.src1 >> slot_req.src2[4:0];
            ALU_SLT: result = {{(XLEN-1){1'b0}},
                               $signed(slot_req.src1) < $signed(slot_req.src2)};
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= slot_busy;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_tag_q  <= slot_tag;
        wb_data_q <= result;
    end

    assign busy_o     = slot_busy;
    assign wb_valid_o = wb_valid_q;
    assign wb_tag_o   = wb_tag_q;
    assign wb_data_o  = wb_data_q;

endmodule

`default_nettype wire

// ==== hdl/ldst_unit.sv ====
`default_nettype none

module ldst_unit
    import helios_cfg_pkg::*;
    import helios_op_pkg::*;
#(
    parameter int ROB_DEPTH = ROB_DEPTH_DEFAULT
) (
    input  wire logic                         clk_i,
    input  wire logic                         rst_n_i,
    input  wire logic                         issue_i,
    input  wire logic [$clog2(ROB_DEPTH)-1:0] tag_i,
    input  wire mem_req_t                     req_i,
    output logic                              busy_o,
    output logic                              wb_valid_o,
    output logic      [$clog2(ROB_DEPTH)-1:0] wb_tag_o,
    output logic      [XLEN-1:0]              wb_data_o,
    output logic                              wb_cyc_o,
    output logic                              wb_stb_o,
    output logic                              wb_we_o,
    output logic      [XLEN-1:0]              wb_adr_o,
    output logic      [XLEN-1:0]              wb_dat_o,
    input  wire logic [XLEN-1:0]              wb_dat_i,
    input  wire logic                         wb_ack_i
);

    localparam int TAG_W = $clog2(ROB_DEPTH);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUS,
        ST_DONE
    } state_e;

    state_e           state_q;
    logic             slot_busy;
    logic [TAG_W-1:0] slot_tag;
    mem_req_t         slot_req;
    logic [XLEN-1:0]  eff_addr;
    logic [XLEN-1:0]  rdata_q;

    // slot stays occupied for the whole bus cycle
    issue_slot #(
        .payload_t(mem_req_t),
        .TAG_W    (TAG_W)
    ) u_slot (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .load_i   (issue_i),
        .tag_i    (tag_i),
        .payload_i(req_i),
        .release_i(state_q == ST_DONE),
        .busy_o   (slot_busy),
        .tag_o    (slot_tag),
        .payload_o(slot_req)
    );

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: if (slot_busy) state_q <= ST_BUS;
                ST_BUS:  if (wb_ack_i) state_q <= ST_DONE;
                ST_DONE: state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // stores write back zero
    always_ff @(posedge clk_i) begin
        if (state_q == ST_BUS && wb_ack_i) begin
            rdata_q <= (slot_req.op == MEM_LW) ? wb_dat_i : '0;
        end
    end

    assign eff_addr = slot_req.base + slot_req.imm;

    assign wb_cyc_o = (state_q == ST_BUS);
    assign wb_stb_o = (state_q == ST_BUS);
    assign wb_we_o  = (slot_req.op == MEM_SW);
    assign wb_adr_o = {eff_addr[XLEN-1:ADDR_LSB], {ADDR_LSB{1'b0}}};
    assign wb_dat_o = slot_req.wdata;

    assign busy_o     = slot_busy;
    assign wb_valid_o = (state_q == ST_DONE);
    assign wb_tag_o   = slot_tag;
    assign wb_data_o  = rdata_q;

endmodule

`default_nettype wire

// ==== hdl/reorder_buffer.sv ====
`default_nettype none

module reorder_buffer
    import helios_cfg_pkg::*;
    import helios_op_pkg::*;
#(
    parameter int ROB_DEPTH = ROB_DEPTH_DEFAULT
) (
    input  wire logic                         clk_i,
    input  wire logic                         rst_n_i,
    input  wire logic                         disp_valid_i,
    output logic                              disp_ready_o,
    input  wire fu_sel_e                      disp_unit_i,
    input  wire alu_op_e                      disp_alu_op_i,
    input  wire mem_op_e                      disp_mem_op_i,
    input  wire logic [XLEN-1:0]              disp_src1_i,
    input  wire logic [XLEN-1:0]              disp_src2_i,
    input  wire logic [XLEN-1:0]              disp_imm_i,
    input  wire logic [REG_SEL-1:0]           disp_rd_i,
    input  wire logic                         disp_wr_i,
    input  wire logic                         alu_busy_i,
    input  wire logic                         mem_busy_i,
    output logic                              alu_issue_o,
    output logic      [$clog2(ROB_DEPTH)-1:0] alu_tag_o,
    output alu_req_t                          alu_req_o,
    output logic                              mem_issue_o,
    output logic      [$clog2(ROB_DEPTH)-1:0] mem_tag_o,
    output mem_req_t                          mem_req_o,
    input  wire logic                         alu_wb_valid_i,
    input  wire logic [$clog2(ROB_DEPTH)-1:0] alu_wb_tag_i,
    input  wire logic [XLEN-1:0]              alu_wb_data_i,
    input  wire logic                         mem_wb_valid_i,
    input  wire logic [$clog2(ROB_DEPTH)-1:0] mem_wb_tag_i,
    input  wire logic [XLEN-1:0]              mem_wb_data_i,
    output logic                              commit_valid_o,
    output logic                              commit_we_o,
    output logic      [REG_SEL-1:0]           commit_rd_o,
    output logic      [XLEN-1:0]              commit_data_o
);

    localparam int TAG_W = $clog2(ROB_DEPTH);

    logic [TAG_W-1:0]   head_q;
    logic [TAG_W-1:0]   tail_q;
    logic [TAG_W:0]     count_q;
    logic [ROB_DEPTH-1:0] done_q;

    logic [REG_SEL-1:0] ent_rd   [ROB_DEPTH];
    logic               ent_wr   [ROB_DEPTH];
    logic [XLEN-1:0]    ent_data [ROB_DEPTH];

    logic full;
    logic unit_free;
    logic fire;
    logic retire;
    logic writes_reg;

    assign full      = (count_q == (TAG_W+1)'(ROB_DEPTH));
    assign unit_free = (disp_unit_i == FU_ALU) ? !alu_busy_i : !mem_busy_i;

    assign disp_ready_o = !full && unit_free;
    assign fire         = disp_valid_i && disp_ready_o;

    // stores never write a register, whatever the flag says
    assign writes_reg = disp_wr_i && (disp_unit_i == FU_ALU || disp_mem_op_i == MEM_LW);

    // route to the selected unit, tagged with the allocated entry
    assign alu_issue_o = fire && (disp_unit_i == FU_ALU);
    assign alu_tag_o   = tail_q;
    assign alu_req_o   = '{op: disp_alu_op_i, src1: disp_src1_i, src2: disp_src2_i};

    assign mem_issue_o = fire && (disp_unit_i == FU_MEM);
    assign mem_tag_o   = tail_q;
    assign mem_req_o   = '{op: disp_mem_op_i, base: disp_src1_i, wdata: disp_src2_i,
                           imm: disp_imm_i};

    assign retire = (count_q != '0) && done_q[head_q];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            done_q  <= '0;
        end else begin
            if (fire) begin
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
            if (alu_wb_valid_i) begin
                done_q[alu_wb_tag_i] <= 1'b1;
            end
            if (mem_wb_valid_i) begin
                done_q[mem_wb_tag_i] <= 1'b1;
            end
            if (retire) begin
                head_q <= head_q + 1'b1;
            end
            case ({fire, retire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (fire) begin
            ent_rd[tail_q] <= disp_rd_i;
            ent_wr[tail_q] <= writes_reg;
        end
        if (alu_wb_valid_i) begin
            ent_data[alu_wb_tag_i] <= alu_wb_data_i;
        end
        if (mem_wb_valid_i) begin
            ent_data[mem_wb_tag_i] <= mem_wb_data_i;
        end
    end

    // x0 is never written
    assign commit_valid_o = retire;
    assign commit_we_o    = retire && ent_wr[head_q] && (ent_rd[head_q] != '0);
    assign commit_rd_o    = ent_rd[head_q];
    assign commit_data_o  = ent_data[head_q];

endmodule

`default_nettype wire

// ==== hdl/helios_backend.sv ====
`default_nettype none

module helios_backend
    import helios_cfg_pkg::*;
    import helios_op_pkg::*;
#(
    parameter int ROB_DEPTH = ROB_DEPTH_DEFAULT
) (
    input  wire logic               clk_i,
    input  wire logic               rst_n_i,
    input  wire logic               disp_valid_i,
    output logic                    disp_ready_o,
    input  wire fu_sel_e            disp_unit_i,
    input  wire alu_op_e            disp_alu_op_i,
    input  wire mem_op_e            disp_mem_op_i,
    input  wire logic [XLEN-1:0]    disp_src1_i,
    input  wire logic [XLEN-1:0]    disp_src2_i,
    input  wire logic [XLEN-1:0]    disp_imm_i,
    input  wire logic [REG_SEL-1:0] disp_rd_i,
    input  wire logic               disp_wr_i,
    output logic                    wb_cyc_o,
    output logic                    wb_stb_o,
    output logic                    wb_we_o,
    output logic      [XLEN-1:0]    wb_adr_o,
    output logic      [XLEN-1:0]    wb_dat_o,
    input  wire logic [XLEN-1:0]    wb_dat_i,
    input  wire logic               wb_ack_i,
    output logic                    commit_valid_o,
    output logic                    commit_we_o,
    output logic      [REG_SEL-1:0] commit_rd_o,
    output logic      [XLEN-1:0]    commit_data_o
);

    localparam int TAG_W = $clog2(ROB_DEPTH);

    logic             alu_issue;
    logic [TAG_W-1:0] alu_tag;
    alu_req_t         alu_req;
    logic             alu_busy;
    logic             alu_wb_valid;
    logic [TAG_W-1:0] alu_wb_tag;
    logic [XLEN-1:0]  alu_wb_data;

    logic             mem_issue;
    logic [TAG_W-1:0] mem_tag;
    mem_req_t         mem_req;
    logic             mem_busy;
    logic             mem_wb_valid;
    logic [TAG_W-1:0] mem_wb_tag;
    logic [XLEN-1:0]  mem_wb_data;

    reorder_buffer #(
        .ROB_DEPTH(ROB_DEPTH)
    ) u_rob (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .disp_valid_i  (disp_valid_i),
        .disp_ready_o  (disp_ready_o),
        .disp_unit_i   (disp_unit_i),
        .disp_alu_op_i (disp_alu_op_i),
        .disp_mem_op_i (disp_mem_op_i),
        .disp_src1_i   (disp_src1_i),
        .disp_src2_i   (disp_src2_i),
        .disp_imm_i    (disp_imm_i),
        .disp_rd_i     (disp_rd_i),
        .disp_wr_i     (disp_wr_i),
        .alu_busy_i    (alu_busy),
        .mem_busy_i    (mem_busy),
        .alu_issue_o   (alu_issue),
        .alu_tag_o     (alu_tag),
        .alu_req_o     (alu_req),
        .mem_issue_o   (mem_issue),
        .mem_tag_o     (mem_tag),
        .mem_req_o     (mem_req),
        .alu_wb_valid_i(alu_wb_valid),
        .alu_wb_tag_i  (alu_wb_tag),
        .alu_wb_data_i (alu_wb_data),
        .mem_wb_valid_i(mem_wb_valid),
        .mem_wb_tag_i  (mem_wb_tag),
        .mem_wb_data_i (mem_wb_data),
        .commit_valid_o(commit_valid_o),
        .commit_we_o   (commit_we_o),
        .commit_rd_o   (commit_rd_o),
        .commit_data_o (commit_data_o)
    );

    alu_unit #(
        .ROB_DEPTH(ROB_DEPTH)
    ) u_alu (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .issue_i   (alu_issue),
        .tag_i     (alu_tag),
        .req_i     (alu_req),
        .busy_o    (alu_busy),
        .wb_valid_o(alu_wb_valid),
        .wb_tag_o  (alu_wb_tag),
        .wb_data_o (alu_wb_data)
    );

    ldst_unit #(
        .ROB_DEPTH(ROB_DEPTH)
    ) u_ldst (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .issue_i   (mem_issue),
        .tag_i     (mem_tag),
        .req_i     (mem_req),
        .busy_o    (mem_busy),
        .wb_valid_o(mem_wb_valid),
        .wb_tag_o  (mem_wb_tag),
        .wb_data_o (mem_wb_data),
        .wb_cyc_o  (wb_cyc_o),
        .wb_stb_o  (wb_stb_o),
        .wb_we_o   (wb_we_o),
        .wb_adr_o  (wb_adr_o),
        .wb_dat_o  (wb_dat_o),
        .wb_dat_i  (wb_dat_i),
        .wb_ack_i  (wb_ack_i)
    );

endmodule

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // released on a falling edge
    initial begin
        rst_n_o = 1'b0;
        #(PERIOD * RST_CYCLES);
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== dv/tb_helios_backend.sv ====
`default_nettype none

module tb_helios_backend
    import helios_cfg_pkg::*;
    import helios_op_pkg::*;
#(
    parameter int ROB_DEPTH = ROB_DEPTH_DEFAULT
);

    localparam int CLK_PERIOD      = 100;
    localparam int COLS            = 9;
    localparam int MAX_LINES       = 64;
    localparam int CYCLES_PER_LINE = 40;
    localparam int MEM_AW          = 6;
    localparam int MEM_WORDS       = 1 << MEM_AW;

    logic               clk;
    logic               rst_n;
    logic               disp_valid;
    logic               disp_ready;
    fu_sel_e            disp_unit;
    alu_op_e            disp_alu_op;
    mem_op_e            disp_mem_op;
    logic [XLEN-1:0]    disp_src1;
    logic [XLEN-1:0]    disp_src2;
    logic [XLEN-1:0]    disp_imm;
    logic [REG_SEL-1:0] disp_rd;
    logic               disp_wr;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic [XLEN-1:0]    wb_adr;
    logic [XLEN-1:0]    wb_dat_w;
    logic [XLEN-1:0]    wb_dat_r = '0;
    logic               wb_ack = 1'b0;
    logic               commit_valid;
    logic               commit_we;
    logic [REG_SEL-1:0] commit_rd;
    logic [XLEN-1:0]    commit_data;

    logic [XLEN-1:0]    stim [MAX_LINES*COLS];
    logic [XLEN-1:0]    mem [MEM_WORDS];
    logic [XLEN-1:0]    exp_data_q [$];
    logic [REG_SEL-1:0] exp_rd_q [$];
    logic               exp_we_q [$];
    int                 stall_q [$];

    int   seed = 92;
    int   num_lines = 0;
    int   commits_seen = 0;
    int   pass_count = 0;
    int   fail_count = 0;
    int   error_count = 0;
    int   cycle_count = 0;
    int   cycle_limit = 0;
    int   ack_wait = 0;
    int   dispatched = 0;
    bit   full_seen = 1'b0;
    logic bus_active = 1'b0;

    tb_clk_gen #(
        .PERIOD    (CLK_PERIOD),
        .RST_CYCLES(4)
    ) u_clk_gen (
        .clk_o  (clk),
        .rst_n_o(rst_n)
    );

    helios_backend #(
        .ROB_DEPTH(ROB_DEPTH)
    ) UUT (
        .clk_i(clk), .rst_n_i(rst_n),
        .disp_valid_i(disp_valid), .disp_ready_o(disp_ready),
        .disp_unit_i(disp_unit), .disp_alu_op_i(disp_alu_op), .disp_mem_op_i(disp_mem_op),
        .disp_src1_i(disp_src1), .disp_src2_i(disp_src2), .disp_imm_i(disp_imm),
        .disp_rd_i(disp_rd), .disp_wr_i(disp_wr),
        .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
        .wb_dat_o(wb_dat_w), .wb_dat_i(wb_dat_r), .wb_ack_i(wb_ack),
        .commit_valid_o(commit_valid), .commit_we_o(commit_we),
        .commit_rd_o(commit_rd), .commit_data_o(commit_data)
    );

    task automatic check_commit_data(input string name, input logic [XLEN-1:0] expected,
                                     input logic [XLEN-1:0] actual, inout bit ok);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
            ok = 1'b0;
        end
    endtask

    task automatic check_commit_rd(input string name, input logic [REG_SEL-1:0] expected,
                                   input logic [REG_SEL-1:0] actual, inout bit ok);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s expected x%0d got x%0d", $time, name, expected, actual);
            ok = 1'b0;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual,
                              inout bit ok);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s expected %b got %b", $time, name, expected, actual);
            ok = 1'b0;
        end
    endtask

    // wishbone slave with a random ack wait plus any stall from the stimulus
    always @(negedge clk) begin
        logic [MEM_AW-1:0] idx;
        if (!rst_n) begin
            wb_ack = 1'b0;
            bus_active = 1'b0;
        end else if (wb_ack) begin
            wb_ack = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!bus_active) begin
                bus_active = 1'b1;
                ack_wait = $unsigned($random(seed)) % 4;
                if (stall_q.size() != 0) begin
                    ack_wait = ack_wait + stall_q.pop_front();
                end
            end
            if (ack_wait == 0) begin
                idx = wb_adr[ADDR_LSB +: MEM_AW];
                if (wb_we) begin
                    mem[idx] = wb_dat_w;
                end else begin
                    wb_dat_r = mem[idx];
                end
                wb_ack = 1'b1;
                bus_active = 1'b0;
            end else begin
                ack_wait = ack_wait - 1;
            end
        end
    end

    // commit outputs are stable through the low phase
    always @(negedge clk) begin
        bit ok;
        if (rst_n && commit_valid) begin
            if (exp_data_q.size() == 0) begin
                $display("t=%0t a commit appeared with no instruction left to retire", $time);
                error_count++;
            end else begin
                ok = 1'b1;
                check_commit_rd("commit_rd_o", exp_rd_q.pop_front(), commit_rd, ok);
                check_flag("commit_we_o", exp_we_q.pop_front(), commit_we, ok);
                check_commit_data("commit_data_o", exp_data_q.pop_front(), commit_data, ok);
                commits_seen++;
                if (ok) begin
                    pass_count++;
                end else begin
                    fail_count++;
                end
                $display("instr %0d: rd x%0d we %b data %h %s", commits_seen, commit_rd,
                         commit_we, commit_data, ok ? "ok" : "mismatch");
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles with %0d of %0d instructions committed",
                     cycle_count, commits_seen, num_lines);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        int  base;
        int  in_flight;
        bit  accepted;
        bit  ok;
        disp_valid  = 1'b0;
        disp_unit   = FU_ALU;
        disp_alu_op = ALU_ADD;
        disp_mem_op = MEM_LW;
        disp_src1   = '0;
        disp_src2   = '0;
        disp_imm    = '0;
        disp_rd     = '0;
        disp_wr     = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'hc0de_0000 | XLEN'(i);
        end
        for (int i = 0; i < MAX_LINES * COLS; i++) begin
            stim[i] = '1;
        end
        $readmemh("dv/backend_stimulus.txt", stim);
        while (num_lines < MAX_LINES && stim[num_lines*COLS] != '1) begin
            num_lines++;
        end
        cycle_limit = CYCLES_PER_LINE * (num_lines + 1);
        // stores and rd zero never write a register
        for (int i = 0; i < num_lines; i++) begin
            base = i * COLS;
            exp_rd_q.push_back(stim[base+5][REG_SEL-1:0]);
            exp_we_q.push_back(stim[base+6][0] && stim[base+5][REG_SEL-1:0] != '0 &&
                               (stim[base][0] == 1'b0 || stim[base+1][0] == 1'b0));
            exp_data_q.push_back(stim[base+7]);
        end

        wait (rst_n === 1'b1);
        @(posedge clk);
        repeat (2) begin
            @(negedge clk);
            ok = 1'b1;
            check_flag("commit_valid_o", 1'b0, commit_valid, ok);
            check_flag("wb_cyc_o", 1'b0, wb_cyc, ok);
            check_flag("wb_stb_o", 1'b0, wb_stb, ok);
            check_flag("disp_ready_o", 1'b1, disp_ready, ok);
            if (!ok) begin
                error_count++;
            end
        end

        for (int i = 0; i < num_lines; i++) begin
            base = i * COLS;
            disp_unit   = fu_sel_e'(stim[base][0]);
            disp_alu_op = alu_op_e'(stim[base+1][2:0]);
            disp_mem_op = mem_op_e'(stim[base+1][0]);
            disp_src1   = stim[base+2];
            disp_src2   = stim[base+3];
            disp_imm    = stim[base+4];
            disp_rd     = stim[base+5][REG_SEL-1:0];
            disp_wr     = stim[base+6][0];
            disp_valid  = 1'b1;
            accepted    = 1'b0;
            // hold until ready is seen before a rising edge
            while (!accepted) begin
                #(CLK_PERIOD / 4);
                // a visible commit has not retired yet
                in_flight = dispatched - commits_seen + int'(commit_valid);
                if (in_flight >= ROB_DEPTH) begin
                    full_seen = 1'b1;
                    ok = 1'b1;
                    check_flag("disp_ready_o", 1'b0, disp_ready, ok);
                    if (!ok) begin
                        error_count++;
                    end
                end
                accepted = disp_ready;
                if (accepted) begin
                    dispatched++;
                    if (disp_unit == FU_MEM) begin
                        stall_q.push_back(int'(stim[base+8]));
                    end
                end
                @(negedge clk);
            end
        end
        disp_valid = 1'b0;

        wait (commits_seen == num_lines);
        repeat (4) @(negedge clk);
        if (!full_seen) begin
            $display("t=%0t the reorder buffer never filled behind the slow load", $time);
            error_count++;
        end
        $display("summary: %0d instructions, %0d committed ok, %0d mismatched, %0d other errors",
                 num_lines, pass_count, fail_count, error_count);
        if (num_lines > 0 && fail_count == 0 && error_count == 0 &&
            commits_seen == num_lines) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/backend_stimulus.txt ====
// unit op src1 src2 imm rd wr expected stall, all hex
// unit 0 is alu and 1 is mem (op 0 lw, 1 sw), stall adds bus wait cycles to a memory access
0 0 00000005 00000007 00000000 01 1 0000000c 0
0 1 00000005 00000007 00000000 02 1 fffffffe 0
0 2 f0f0f0f0 ff00ff00 00000000 03 1 f000f000 0
0 3 f0f0f0f0 0f0f0000 00000000 04 1 fffff0f0 0
0 4 aaaaaaaa ffff0000 00000000 05 1 5555aaaa 0
0 5 00000003 00000024 00000000 06 1 00000030 0
0 6 80000000 0000001f 00000000 07 1 00000001 0
0 7 fffffffe 00000001 00000000 08 1 00000001 0
0 7 00000001 ffffffff 00000000 09 1 00000000 0
1 1 00000040 12345678 00000004 0b 1 00000000 0
1 0 00000040 00000000 00000004 0a 1 12345678 0
1 0 00000000 00000000 00000014 0b 1 c0de0005 0
1 0 00000040 00000000 00000004 0c 1 12345678 6
0 0 00000001 00000001 00000000 0d 1 00000002 0
0 4 0000ffff 000000ff 00000000 0e 1 0000ff00 0
1 0 00000000 00000000 000000fc 0f 1 c0de003f 18
0 0 00000010 00000001 00000000 10 1 00000011 0
0 0 00000011 00000001 00000000 11 1 00000012 0
0 0 00000012 00000001 00000000 12 1 00000013 0
0 0 00000013 00000001 00000000 13 1 00000014 0
0 0 00000014 00000001 00000000 14 1 00000015 0
0 0 00000015 00000001 00000000 15 1 00000016 0
0 0 00000016 00000001 00000000 16 1 00000017 0
0 0 00000003 00000004 00000000 00 1 00000007 0

// ==== sources.f ====
hdl/helios_cfg_pkg.sv
hdl/helios_op_pkg.sv
hdl/issue_slot.sv
hdl/alu_unit.sv
hdl/ldst_unit.sv
hdl/reorder_buffer.sv
hdl/helios_backend.sv
dv/tb_clk_gen.sv
dv/tb_helios_backend.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
    verilator --binary --top-module tb_helios_backend -f sources.f -o sim_backend &&
    ./obj_dir/sim_backend | tee /dev/stderr | grep -q "Regression passed" &&
    echo "run.sh: simulation PASS" ||
    { echo "run.sh: simulation FAIL"; exit 1; }
